// File: vlog.f
+incdir+source
source/axi_master_pkg.sv
source/burst_ctrl.sv
source/addr_chan.sv
source/write_data_chan.sv
source/read_data_chan.sv
source/axi_master_top.sv
verif/axi_master_assert.sv
verif/axi_master_tb.sv

// File: verif/axi_master_tb.sv
// Directed testbench of the AXI4 burst master with an AXI slave model and a DMA driver
`include "axi_master_config.svh"

module axi_master_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import axi_master_pkg::*;

  // Recorded AW or AR command
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [3:0] cache;
  } cmd_rec_t;

  // Recorded W beat
  typedef struct packed {
    data_t      data;
    logic [3:0] strb;
    logic       last;
  } wbeat_rec_t;

  // R beat as the DMA saw it
  typedef struct packed {
    data_t     data;
    beat_idx_t idx;
    logic      rack;
  } rbeat_rec_t;

  // Beats of all bursts below
  localparam int total_beats     = 4 + 15 + 6 + 1 + 1 + 3 + 5;
  localparam int watchdog_cycles = total_beats * 20 + 200;
  // Limit for a single burst
  localparam int burst_cycles    = 200;
  localparam logic [31:0] seed   = 32'h615a_93d3;

  logic M_AXI_ACLK;
  logic M_AXI_ARESETN;
  addr_t m_axi_awaddr;
  logic [7:0] m_axi_awlen;
  logic [2:0] m_axi_awsize;
  logic [1:0] m_axi_awburst;
  logic [3:0] m_axi_awcache;
  logic m_axi_awvalid;
  logic m_axi_awready;
  data_t m_axi_wdata;
  logic [3:0] m_axi_wstrb;
  logic m_axi_wlast;
  logic m_axi_wvalid;
  logic m_axi_wready;
  logic m_axi_bvalid;
  logic m_axi_bready;
  addr_t m_axi_araddr;
  logic [7:0] m_axi_arlen;
  logic [2:0] m_axi_arsize;
  logic [1:0] m_axi_arburst;
  logic [3:0] m_axi_arcache;
  logic m_axi_arvalid;
  logic m_axi_arready;
  data_t m_axi_rdata;
  logic m_axi_rlast;
  logic m_axi_rvalid;
  logic m_axi_rready;
  dma_req_t dma_req;
  data_t dma_wdata;
  logic dma_wack;
  logic dma_wresp;
  data_t dma_rdata;
  logic dma_rack;
  beat_idx_t read_index;
  logic wcomplete;
  logic rcomplete;

  // Two LFSRs from one seed, so delays and data do not interleave
  logic [31:0] delay_lfsr;
  logic [31:0] data_lfsr;
  bit rand_ready;

  // Slave model state
  int aw_wait;
  int w_wait;
  int ar_wait;
  int r_wait;
  int r_beat;
  int r_count;
  addr_t r_base;
  bit aw_got;
  bit wlast_got;
  bit b_hs;
  bit r_hs;

  // Monitor records
  cmd_rec_t   aw_q[$];
  cmd_rec_t   ar_q[$];
  wbeat_rec_t w_q[$];
  rbeat_rec_t r_q[$];
  int wcomp_cnt;
  int rcomp_cnt;
  // B handshakes of the current burst
  int b_cnt;

  axi_master_top dut (.*);

  initial
  begin
    M_AXI_ACLK = 1'b0;
    forever #5 M_AXI_ACLK = ~M_AXI_ACLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers
  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_step(inout logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    state = {state[30:0], fb};
    return fb;
  endfunction

  function automatic data_t rand_word();
    data_t w;
    for (int i = 0; i < 32; i++)
    begin
      w[i] = lfsr_step(data_lfsr);
    end
    return w;
  endfunction

  // Ready delay of 0 to 3 cycles, zero when random delays are off
  function automatic int draw_delay();
    logic [1:0] d;
    d = 2'd0;
    if (rand_ready)
    begin
      d[1] = lfsr_step(delay_lfsr);
      d[0] = lfsr_step(delay_lfsr);
    end
    return d;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Error handling
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_bound_assertions();
    assert (dut.u_assert.fail_cnt == 0)
    else fail_run("A bound AXI protocol assertion failed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Slave model
  // Runs on the falling edge, sections ordered so a flag set here acts next cycle
  always @(negedge M_AXI_ACLK)
  begin
    if (M_AXI_ARESETN)
    begin
      // B, once both AW and the last W beat went through
      if (b_hs)
      begin
        m_axi_bvalid = 1'b0;
        b_hs = 1'b0;
      end
      else if (m_axi_bvalid && m_axi_bready)
      begin
        b_hs = 1'b1;
      end
      else if (!m_axi_bvalid && aw_got && wlast_got)
      begin
        m_axi_bvalid = 1'b1;
        aw_got = 1'b0;
        wlast_got = 1'b0;
      end
      // R, data is the read address plus the beat number
      if (r_hs)
      begin
        m_axi_rvalid = 1'b0;
        r_hs = 1'b0;
        r_beat++;
        r_wait = draw_delay();
      end
      else if (m_axi_rvalid && m_axi_rready)
      begin
        r_hs = 1'b1;
      end
      else if (!m_axi_rvalid && (r_beat < r_count))
      begin
        if (r_wait == 0)
        begin
          m_axi_rvalid = 1'b1;
          m_axi_rdata = r_base + r_beat;
          m_axi_rlast = (r_beat == r_count - 1);
        end
        else
        begin
          r_wait--;
        end
      end
      // AW
      if (m_axi_awready)
      begin
        m_axi_awready = 1'b0;
        aw_got = 1'b1;
        aw_wait = draw_delay();
      end
      else if (m_axi_awvalid)
      begin
        if (aw_wait == 0)
        begin
          m_axi_awready = 1'b1;
        end
        else
        begin
          aw_wait--;
        end
      end
      // W
      if (m_axi_wready)
      begin
        m_axi_wready = 1'b0;
        w_wait = draw_delay();
      end
      else if (m_axi_wvalid)
      begin
        if (w_wait == 0)
        begin
          m_axi_wready = 1'b1;
          wlast_got = wlast_got | m_axi_wlast;
        end
        else
        begin
          w_wait--;
        end
      end
      // AR, burst starts next cycle from the held address
      if (m_axi_arready)
      begin
        m_axi_arready = 1'b0;
        r_base = m_axi_araddr;
        r_count = m_axi_arlen + 1;
        r_beat = 0;
        r_wait = draw_delay();
        ar_wait = draw_delay();
      end
      else if (m_axi_arvalid)
      begin
        if (ar_wait == 0)
        begin
          m_axi_arready = 1'b1;
        end
        else
        begin
          ar_wait--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor
  // Samples pre-edge values, i.e. what each handshake transferred
  always @(posedge M_AXI_ACLK)
  begin
    if (M_AXI_ARESETN)
    begin
      if (m_axi_awvalid && m_axi_awready)
      begin
        aw_q.push_back('{m_axi_awaddr, m_axi_awlen, m_axi_awsize, m_axi_awburst,
                         m_axi_awcache});
      end
      if (m_axi_arvalid && m_axi_arready)
      begin
        ar_q.push_back('{m_axi_araddr, m_axi_arlen, m_axi_arsize, m_axi_arburst,
                         m_axi_arcache});
      end
      if (m_axi_wvalid && m_axi_wready)
      begin
        w_q.push_back('{m_axi_wdata, m_axi_wstrb, m_axi_wlast});
      end
      if (m_axi_bvalid && m_axi_bready)
      begin
        b_cnt++;
      end
      if (m_axi_rvalid && m_axi_rready)
      begin
        r_q.push_back('{dma_rdata, read_index, dma_rack});
      end
      wcomp_cnt += wcomplete;
      rcomp_cnt += rcomplete;
    end
  end

  // Bound assertions count their failures
  always @(negedge M_AXI_ACLK)
  begin
    check_bound_assertions();
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge M_AXI_ACLK);
    fail_run($sformatf("Watchdog expired after %0d cycles, tests did not finish",
                       watchdog_cycles));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Burst helpers
  task automatic clear_records();
    aw_q.delete();
    ar_q.delete();
    w_q.delete();
    r_q.delete();
    wcomp_cnt = 0;
    rcomp_cnt = 0;
    b_cnt = 0;
  endtask

  task automatic check_cmd(input string ch, input cmd_rec_t c, input addr_t a, input int len);
    check_value({"m_axi_", ch, "addr"}, c.addr, `AXI_TARGET_BASE | a);
    check_value({"m_axi_", ch, "len"}, c.len, len - 1);
    check_value({"m_axi_", ch, "size"}, c.size, `AXI_SIZE_WORD);
    check_value({"m_axi_", ch, "burst"}, c.burst, `AXI_BURST_INCR);
    check_value({"m_axi_", ch, "cache"}, c.cache, `AXI_CACHE_NONE);
  endtask

  // DMA hands over len words, then waits for wcomplete
  task automatic write_burst(input int len, input addr_t waddr);
    data_t words[$];
    int    sent;
    int    cycles;
    bit    done;
    for (int i = 0; i < len; i++)
    begin
      words.push_back(rand_word());
    end
    @(negedge M_AXI_ACLK);
    clear_records();
    dma_req = '{start: 1'b1, is_write: 1'b1, waddr: waddr, raddr: '0, burst_len: len[3:0]};
    dma_wdata = words[0];
    dma_wack = 1'b1;
    sent = 0;
    cycles = 0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge M_AXI_ACLK);
      cycles++;
      // Word taken, move on to the next one
      if (dma_wresp)
      begin
        sent++;
        if (sent < len)
        begin
          dma_wdata = words[sent];
        end
        else
        begin
          dma_wack = 1'b0;
        end
      end
      if (wcomplete)
      begin
        // Strobe only once the write response was taken
        check_value("B handshakes", b_cnt, 1);
        done = 1'b1;
        dma_req.start = 1'b0;
      end
      else
      begin
        assert (cycles < burst_cycles)
        else fail_run($sformatf("Write burst of %0d beats did not complete", len));
      end
    end
    // Room for a stray second strobe
    repeat (4) @(negedge M_AXI_ACLK);
    check_value("dma_wresp pulses", sent, len);
    check_value("wcomplete pulses", wcomp_cnt, 1);
    check_value("rcomplete pulses", rcomp_cnt, 0);
    check_value("AW handshakes", aw_q.size(), 1);
    check_value("AR handshakes", ar_q.size(), 0);
    check_cmd("aw", aw_q[0], waddr, len);
    check_value("W beats", w_q.size(), len);
    foreach (w_q[i])
    begin
      check_value($sformatf("m_axi_wdata[%0d]", i), w_q[i].data, words[i]);
      check_value("m_axi_wstrb", w_q[i].strb, 4'hf);
      check_value($sformatf("m_axi_wlast[%0d]", i), w_q[i].last, i == len - 1);
    end
  endtask

  // Starts a read and waits for rcomplete
  task automatic read_burst(input int len, input addr_t raddr);
    int cycles;
    bit done;
    @(negedge M_AXI_ACLK);
    clear_records();
    dma_req = '{start: 1'b1, is_write: 1'b0, waddr: '0, raddr: raddr, burst_len: len[3:0]};
    cycles = 0;
    done = 1'b0;
    while (!done)
    begin
      @(negedge M_AXI_ACLK);
      cycles++;
      if (rcomplete)
      begin
        done = 1'b1;
        dma_req.start = 1'b0;
      end
      else
      begin
        assert (cycles < burst_cycles)
        else fail_run($sformatf("Read burst of %0d beats did not complete", len));
      end
    end
    repeat (4) @(negedge M_AXI_ACLK);
    check_value("rcomplete pulses", rcomp_cnt, 1);
    check_value("wcomplete pulses", wcomp_cnt, 0);
    check_value("AR handshakes", ar_q.size(), 1);
    check_value("AW handshakes", aw_q.size(), 0);
    check_cmd("ar", ar_q[0], raddr, len);
    check_value("R beats", r_q.size(), len);
    foreach (r_q[i])
    begin
      check_value($sformatf("dma_rdata[%0d]", i), r_q[i].data,
                  (`AXI_TARGET_BASE | raddr) + i);
      check_value($sformatf("read_index[%0d]", i), r_q[i].idx, i);
      check_value("dma_rack", r_q[i].rack, 1'b1);
    end
    check_value("read_index", read_index, len - 1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  task automatic idle_after_reset();
    @(negedge M_AXI_ACLK);
    check_value("m_axi_awvalid", m_axi_awvalid, 1'b0);
    check_value("m_axi_arvalid", m_axi_arvalid, 1'b0);
    check_value("m_axi_wvalid", m_axi_wvalid, 1'b0);
    check_value("m_axi_wlast", m_axi_wlast, 1'b0);
    check_value("m_axi_bready", m_axi_bready, 1'b0);
    check_value("m_axi_rready", m_axi_rready, 1'b0);
    check_value("dma_wresp", dma_wresp, 1'b0);
    check_value("wcomplete", wcomplete, 1'b0);
    check_value("rcomplete", rcomplete, 1'b0);
    check_value("read_index", read_index, 4'd0);
    check_value("u_ctrl.state", dut.u_ctrl.state, ST_IDLE);
  endtask

  task automatic write_four_beats();
    rand_ready = 1'b0;
    write_burst(4, 32'h0000_1040);
  endtask

  task automatic write_fifteen_stalled();
    rand_ready = 1'b1;
    write_burst(15, 32'h0001_0200);
  endtask

  task automatic read_six_beats();
    rand_ready = 1'b1;
    read_burst(6, 32'h0000_3000);
  endtask

  task automatic single_beat_bursts();
    rand_ready = 1'b1;
    write_burst(1, 32'h0000_0010);
    read_burst(1, 32'h0000_0020);
  endtask

  // Second burst only starts if the FSM went back to idle
  task automatic write_then_read();
    rand_ready = 1'b1;
    write_burst(3, 32'h0000_5000);
    check_value("u_ctrl.state", dut.u_ctrl.state, ST_IDLE);
    read_burst(5, 32'h0000_6000);
    check_value("u_ctrl.state", dut.u_ctrl.state, ST_IDLE);
  endtask

  initial
  begin
    M_AXI_ARESETN = 1'b0;
    dma_req = '0;
    dma_wdata = '0;
    dma_wack = 1'b0;
    m_axi_awready = 1'b0;
    m_axi_wready = 1'b0;
    m_axi_bvalid = 1'b0;
    m_axi_arready = 1'b0;
    m_axi_rdata = '0;
    m_axi_rlast = 1'b0;
    m_axi_rvalid = 1'b0;
    delay_lfsr = seed;
    data_lfsr = seed;
    rand_ready = 1'b0;
    {aw_wait, w_wait, ar_wait, r_wait, r_beat, r_count} = '0;
    r_base = '0;
    {aw_got, wlast_got, b_hs, r_hs} = '0;
    // Two rising edges in reset, released on the falling edge after
    repeat (2) @(posedge M_AXI_ACLK);
    @(negedge M_AXI_ACLK);
    M_AXI_ARESETN = 1'b1;
    idle_after_reset();
    write_four_beats();
    write_fifteen_stalled();
    read_six_beats();
    single_beat_bursts();
    write_then_read();
    check_bound_assertions();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: verif/axi_master_assert.sv
// AXI protocol assertions, bound into axi_master_top and watched by the testbench via fail_cnt
module axi_master_assert (
  input logic                  M_AXI_ACLK,
  input logic                  M_AXI_ARESETN,
  input axi_master_pkg::addr_t m_axi_awaddr,
  input logic                  m_axi_awvalid,
  input logic                  m_axi_awready,
  input axi_master_pkg::addr_t m_axi_araddr,
  input logic                  m_axi_arvalid,
  input logic                  m_axi_arready,
  input axi_master_pkg::data_t m_axi_wdata,
  input logic                  m_axi_wlast,
  input logic                  m_axi_wvalid,
  input logic                  m_axi_wready,
  input logic                  m_axi_bready,
  input logic                  wcomplete,
  input logic                  rcomplete
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Address channels
  // Valid and address hold until the slave takes them
  aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    (m_axi_awvalid && !m_axi_awready) |=> (m_axi_awvalid && $stable(m_axi_awaddr)))
  else
  begin
    $error("AWVALID or AWADDR changed before AWREADY");
    fail_cnt++;
  end

  ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    (m_axi_arvalid && !m_axi_arready) |=> (m_axi_arvalid && $stable(m_axi_araddr)))
  else
  begin
    $error("ARVALID or ARADDR changed before ARREADY");
    fail_cnt++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // W channel
  // Data and last flag frozen while the beat waits
  w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    (m_axi_wvalid && !m_axi_wready)
      |=> (m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wlast)))
  else
  begin
    $error("WVALID, WDATA or WLAST changed before WREADY");
    fail_cnt++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pulses
  b_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    m_axi_bready |=> !m_axi_bready)
  else
  begin
    $error("BREADY high for more than one cycle");
    fail_cnt++;
  end

  // One burst in flight, so never both strobes
  done_excl: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    !(wcomplete && rcomplete))
  else
  begin
    $error("wcomplete and rcomplete high together");
    fail_cnt++;
  end

endmodule

bind axi_master_top axi_master_assert u_assert (.*);

// File: source/axi_master_top.sv
// AXI4 burst master top, connects the DMA request port to the AW, W, B, AR and R channels
`include "axi_master_config.svh"

module axi_master_top (
  // Clock and reset
  input  logic                               M_AXI_ACLK,
  input  logic                               M_AXI_ARESETN,
  // AW channel
  output axi_master_pkg::addr_t              m_axi_awaddr,
  output logic [7:0]                         m_axi_awlen,
  output logic [2:0]                         m_axi_awsize,
  output logic [1:0]                         m_axi_awburst,
  output logic [3:0]                         m_axi_awcache,
  output logic                               m_axi_awvalid,
  input  logic                               m_axi_awready,
  // W channel
  output axi_master_pkg::data_t              m_axi_wdata,
  output logic [`AXI_DATA_WIDTH/8-1:0]       m_axi_wstrb,
  output logic                               m_axi_wlast,
  output logic                               m_axi_wvalid,
  input  logic                               m_axi_wready,
  // B channel, response code not looked at
  input  logic                               m_axi_bvalid,
  output logic                               m_axi_bready,
  // AR channel
  output axi_master_pkg::addr_t              m_axi_araddr,
  output logic [7:0]                         m_axi_arlen,
  output logic [2:0]                         m_axi_arsize,
  output logic [1:0]                         m_axi_arburst,
  output logic [3:0]                         m_axi_arcache,
  output logic                               m_axi_arvalid,
  input  logic                               m_axi_arready,
  // R channel, burst end comes from the beat counter and not from RLAST
  input  axi_master_pkg::data_t              m_axi_rdata,
  input  logic                               m_axi_rlast,
  input  logic                               m_axi_rvalid,
  output logic                               m_axi_rready,
  // DMA side
  input  axi_master_pkg::dma_req_t           dma_req,
  input  axi_master_pkg::data_t              dma_wdata,
  input  logic                               dma_wack,
  output logic                               dma_wresp,
  output axi_master_pkg::data_t              dma_rdata,
  output logic                               dma_rack,
  output axi_master_pkg::beat_idx_t          read_index,
  // Completion strobes
  output logic                               wcomplete,
  output logic                               rcomplete
);

  import axi_master_pkg::*;

  // Issue pulses from the controller
  logic issue_wr;
  logic issue_rd;

  // Done pulses back to the controller
  logic wr_done;
  logic rd_done;

  // AxLEN is beats minus one, upper nibble always zero
  burst_len_t len_m1;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed attributes and burst length
  assign len_m1        = dma_req.burst_len - 4'd1;
  assign m_axi_awlen   = {4'd0, len_m1};
  assign m_axi_arlen   = {4'd0, len_m1};
  assign m_axi_awsize  = `AXI_SIZE_WORD;
  assign m_axi_arsize  = `AXI_SIZE_WORD;
  assign m_axi_awburst = `AXI_BURST_INCR;
  assign m_axi_arburst = `AXI_BURST_INCR;
  assign m_axi_awcache = `AXI_CACHE_NONE;
  assign m_axi_arcache = `AXI_CACHE_NONE;
  // Full words only
  assign m_axi_wstrb   = {(`AXI_DATA_WIDTH/8){1'b1}};

  // Read data goes straight through to the DMA
  assign dma_rdata = m_axi_rdata;
  assign dma_rack  = m_axi_rvalid;

  assign wcomplete = wr_done;
  assign rcomplete = rd_done;

  ////////////////////////////////////////////////////////////////////////////
  // Controller
  burst_ctrl u_ctrl (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .start         (dma_req.start),
    .is_write      (dma_req.is_write),
    .wr_done       (wr_done),
    .rd_done       (rd_done),
    .issue_wr      (issue_wr),
    .issue_rd      (issue_rd)
  );

  // Write address
  addr_chan u_aw (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .issue         (issue_wr),
    .dma_addr      (dma_req.waddr),
    .ready         (m_axi_awready),
    .valid         (m_axi_awvalid),
    .addr          (m_axi_awaddr)
  );

  // Read address
  addr_chan u_ar (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .issue         (issue_rd),
    .dma_addr      (dma_req.raddr),
    .ready         (m_axi_arready),
    .valid         (m_axi_arvalid),
    .addr          (m_axi_araddr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data channels
  write_data_chan u_wdata (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .start         (dma_req.start),
    .burst_len     (dma_req.burst_len),
    .dma_wdata     (dma_wdata),
    .dma_wack      (dma_wack),
    .dma_wresp     (dma_wresp),
    .wready        (m_axi_wready),
    .wdata         (m_axi_wdata),
    .wvalid        (m_axi_wvalid),
    .wlast         (m_axi_wlast),
    .bvalid        (m_axi_bvalid),
    .bready        (m_axi_bready),
    .wr_done       (wr_done)
  );

  read_data_chan u_rdata (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .start         (dma_req.start),
    .burst_len     (dma_req.burst_len),
    .rvalid        (m_axi_rvalid),
    .rready        (m_axi_rready),
    .read_index    (read_index),
    .rd_done       (rd_done)
  );

endmodule

// File: source/read_data_chan.sv
// AXI R channel logic, paces rready, counts read beats and reports read completion
module read_data_chan (
  input  logic                       M_AXI_ACLK,
  input  logic                       M_AXI_ARESETN,
  // DMA request level and length
  input  logic                       start,
  input  axi_master_pkg::burst_len_t burst_len,
  // R channel handshake
  input  logic                       rvalid,
  output logic                       rready,
  // Beats accepted so far, to the DMA
  output axi_master_pkg::beat_idx_t  read_index,
  // Completion to the controller
  output logic                       rd_done
);

  import axi_master_pkg::*;

  logic start_q;
  // First cycle of start
  logic new_burst;
  // R beat accepted
  logic rnext;

  beat_idx_t last_idx;

  assign new_burst = start && !start_q;
  assign rnext     = rvalid && rready;
  assign last_idx  = burst_len - 4'd1;

  ////////////////////////////////////////////////////////////////////////////
  // rready and start edge
  // One-cycle rready after rvalid is seen
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      start_q <= 1'b0;
      rready  <= 1'b0;
    end
    else
    begin
      start_q <= start;
      rready  <= rvalid && !rready;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat index and done
  // Saturates at burst_len-1, done on the handshake at that index
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      read_index <= '0;
      rd_done    <= 1'b0;
    end
    else
    begin
      rd_done <= rnext && (read_index == last_idx);
      if (new_burst)
      begin
        read_index <= '0;
      end
      else if (rnext && (read_index != last_idx))
      begin
        read_index <= read_index + 4'd1;
      end
    end
  end

endmodule

// File: source/write_data_chan.sv
// AXI W and B channel logic, moves DMA words onto W and reports write completion
module write_data_chan (
  input  logic                       M_AXI_ACLK,
  input  logic                       M_AXI_ARESETN,
  // DMA request level and length
  input  logic                       start,
  input  axi_master_pkg::burst_len_t burst_len,
  // DMA word handshake
  input  axi_master_pkg::data_t      dma_wdata,
  input  logic                       dma_wack,
  output logic                       dma_wresp,
  // W channel
  input  logic                       wready,
  output axi_master_pkg::data_t      wdata,
  output logic                       wvalid,
  output logic                       wlast,
  // B channel
  input  logic                       bvalid,
  output logic                       bready,
  // Completion to the controller
  output logic                       wr_done
);

  import axi_master_pkg::*;

  logic start_q;
  // First cycle of start, the controller leaves idle here
  logic new_burst;
  // W beat accepted
  logic wnext;
  // Last beat went out
  logic all_sent;
  // Word capture this cycle
  logic take_word;

  beat_idx_t beat_idx;
  beat_idx_t last_idx;

  assign new_burst = start && !start_q;
  assign wnext     = wvalid && wready;
  assign last_idx  = burst_len - 4'd1;
  // Nothing taken while the counter clears or after the final beat
  assign take_word = !wvalid && dma_wack && !all_sent && !new_burst;

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      start_q <= 1'b0;
    end
    else
    begin
      start_q <= start;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat counter
  // Index of the beat now being presented, stops at burst_len-1
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      beat_idx <= '0;
      all_sent <= 1'b0;
    end
    else if (new_burst)
    begin
      beat_idx <= '0;
      all_sent <= 1'b0;
    end
    else if (wnext)
    begin
      if (beat_idx != last_idx)
      begin
        beat_idx <= beat_idx + 4'd1;
      end
      if (wlast)
      begin
        all_sent <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // W valid, last and DMA response
  // dma_wresp is a one-cycle ack per captured word
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      wvalid    <= 1'b0;
      wlast     <= 1'b0;
      dma_wresp <= 1'b0;
    end
    else
    begin
      dma_wresp <= 1'b0;
      if (take_word)
      begin
        wvalid    <= 1'b1;
        wlast     <= (beat_idx == last_idx);
        dma_wresp <= 1'b1;
      end
      else if (wnext)
      begin
        wvalid <= 1'b0;
        wlast  <= 1'b0;
      end
    end
  end

  // Data register, stable while wvalid is up
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (take_word)
    begin
      wdata <= dma_wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // B channel
  // bready pulses once after bvalid is seen
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      bready  <= 1'b0;
      wr_done <= 1'b0;
    end
    else
    begin
      bready  <= bvalid && !bready;
      // Completion only for a response that follows the full burst
      wr_done <= bvalid && bready && all_sent;
    end
  end

endmodule

// File: source/addr_chan.sv
// AXI address channel, latches the command address on issue and holds valid until ready
`include "axi_master_config.svh"

module addr_chan (
  input  logic                  M_AXI_ACLK,
  input  logic                  M_AXI_ARESETN,
  // Pulse from the controller
  input  logic                  issue,
  // Offset from the DMA
  input  axi_master_pkg::addr_t dma_addr,
  // AxREADY / AxVALID / AxADDR
  input  logic                  ready,
  output logic                  valid,
  output axi_master_pkg::addr_t addr
);

  ////////////////////////////////////////////////////////////////////////////
  // Valid
  // Up one edge after issue, down on the edge that sees ready
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      valid <= 1'b0;
    end
    else if (issue)
    begin
      valid <= 1'b1;
    end
    else if (valid && ready)
    begin
      valid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address
  // Slave window ORed in at capture
  // Held for the whole burst, no increment
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (issue)
    begin
      addr <= dma_addr | `AXI_TARGET_BASE;
    end
  end

endmodule

// File: source/burst_ctrl.sv
// Burst controller FSM, turns a DMA start into one AW or AR issue pulse and waits for done
module burst_ctrl (
  input  logic M_AXI_ACLK,
  input  logic M_AXI_ARESETN,
  // DMA request level and direction
  input  logic start,
  input  logic is_write,
  // One-cycle done pulses from the data channels
  input  logic wr_done,
  input  logic rd_done,
  // One-cycle issue pulses to the address channels
  output logic issue_wr,
  output logic issue_rd
);

  import axi_master_pkg::*;

  ctrl_state_t state;

  // Set once the command of this burst went out
  logic issued;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  // Idle -> write or read on start, back to idle on the matching done
  // Issue follows one cycle after the state change
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      state    <= ST_IDLE;
      issued   <= 1'b0;
      issue_wr <= 1'b0;
      issue_rd <= 1'b0;
    end
    else
    begin
      // Issue strobes are pulses
      issue_wr <= 1'b0;
      issue_rd <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          issued <= 1'b0;
          if (start)
          begin
            state <= is_write ? ST_WRITE : ST_READ;
          end
        end
        ST_WRITE:
        begin
          if (wr_done)
          begin
            state <= ST_IDLE;
          end
          else if (start && !issued)
          begin
            // Single AW per burst
            issue_wr <= 1'b1;
            issued   <= 1'b1;
          end
        end
        ST_READ:
        begin
          if (rd_done)
          begin
            state <= ST_IDLE;
          end
          else if (start && !issued)
          begin
            // Single AR per burst
            issue_rd <= 1'b1;
            issued   <= 1'b1;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: source/axi_master_pkg.sv
// Shared types of the AXI4 burst master, imported by the RTL modules and the testbench
`include "axi_master_config.svh"

package axi_master_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Plain vectors with a meaning

  // Byte address on AW and AR
  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;

  // One W or R data word
  typedef logic [`AXI_DATA_WIDTH-1:0] data_t;

  // Beat number inside a burst, 0 .. 14
  typedef logic [3:0] beat_idx_t;

  // Beats per burst as asked by the DMA, 1 .. 15
  typedef logic [3:0] burst_len_t;

  ////////////////////////////////////////////////////////////////////////////
  // DMA request, 70 bits
  typedef struct packed {
    // Level, held while the burst is being set up
    logic       start;
    // 1 for a write burst, 0 for a read burst
    logic       is_write;
    addr_t      waddr;
    addr_t      raddr;
    burst_len_t burst_len;
  } dma_req_t;

  ////////////////////////////////////////////////////////////////////////////
  // Controller FSM
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_WRITE = 2'd1,
    ST_READ  = 2'd2
  } ctrl_state_t;

endpackage

// File: source/axi_master_config.svh
// Build-time constants of the AXI4 burst master, included by the package and the RTL modules
`ifndef AXI_MASTER_CONFIG_SVH
`define AXI_MASTER_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
// Data width is fixed at 32, the size code below assumes 4-byte beats
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32

// Slave window, ORed into every AW and AR address
`define AXI_TARGET_BASE 32'h2000_0000

////////////////////////////////////////////////////////////////////////////
// Fixed AXI attributes
// 2**2 bytes per beat
`define AXI_SIZE_WORD 3'd2
`define AXI_BURST_INCR 2'b01
// Device non-bufferable
`define AXI_CACHE_NONE 4'b0000

`endif
